// ==== pocket_video.f ====
+incdir+hw
hw/pocket_video_pkg.sv
hw/bridge_settings.sv
hw/video_timing_stage.sv
hw/video_pixel_stage.sv
hw/pocket_video_top.sv
verif/pocket_video_assert.sv
verif/pocket_video_tb.sv

// ==== Makefile ====
# Verilator build and run of the pocket video testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= pocket_video_tb
FILELIST  ?= pocket_video.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/pocket_video_tb.sv ====
// pocket video testbench
// table of bridge writes, idle stretches and video ticks with random
// pix_ce gaps and the outputs expected after each row

`timescale 1ns/1ps

`include "pocket_video_consts.svh"

module pocket_video_tb
  import pocket_video_pkg::*;
();

  localparam int MAX_GAP = 3;

  typedef enum logic [1:0] {ROW_WRITE, ROW_TICK, ROW_IDLE} row_kind_e;

  typedef struct packed {
    row_kind_e      kind;
    logic [31:0]    addr;
    logic [31:0]    data;
    logic [15:0]    count;
    vid_in_t        vin;
    logic           isv;
    core_settings_t exp_set;
    vid_out_t       exp_vid;
  } row_t;

  logic                 clk_74a;
  logic                 rst_n;
  logic                 bridge_wr;
  logic [`BRIDGE_W-1:0] bridge_addr;
  logic [`BRIDGE_W-1:0] bridge_wr_data;
  logic                 pix_ce;
  vid_in_t              vid_in;
  logic                 is_vertical;
  core_settings_t       core_settings;
  logic                 core_reset;
  vid_out_t             vid_out;

  row_t rows[$];
  int   hold_left;
  int   cycle_count;
  int   cycle_limit;

  // reference model state advanced while the table is built
  core_settings_t m_set;
  logic [23:0]    m_s1_rgb;
  logic           m_s1_de;
  logic           m_s1_fall;
  logic           m_s1_vs;
  logic           m_prev_de;
  logic           m_prev_hs;
  logic           m_prev_vs;
  int             m_hs_left;

  pocket_video_top pocket_video_top_i (.*);

  bind pocket_video_top pocket_video_assert pocket_video_assert_i (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .pix_ce  (pix_ce),
    .vid_out (vid_out)
  );

  initial begin
    clk_74a = 1'b0;
    forever #20 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_settings(core_settings_t exp, core_settings_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t core_settings expected %h actual %h", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_video(vid_out_t exp, vid_out_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t vid_out expected %h actual %h", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // advance one clock and follow the reset hold in the model
  task automatic next_cycle();
    logic rst_wr;
    rst_wr = bridge_wr && (bridge_addr == `ADDR_RESET);
    @(posedge clk_74a);
    #2;
    if (rst_wr) begin
      hold_left = `RESET_HOLD_CYCLES;
    end else if (hold_left != 0) begin
      hold_left--;
    end
    check_bit("core_reset", hold_left != 0, core_reset);
  endtask

  ////////////////////////////////////////////////////////////
  // table rows and reference model

  function automatic void write_row(logic [31:0] addr, logic [31:0] data);
    row_t r;
    r = '0;
    case (addr)
      `ADDR_SYSTEM:     m_set.system = data[1:0];
      `ADDR_TURBO:      m_set.cpu_turbo = data[0];
      `ADDR_REWIND:     m_set.rewind_capture = data[0];
      `ADDR_TRIPLE_BUF: m_set.triple_buffer = data[0];
      `ADDR_FLICKER:    m_set.flickerblend = data[1:0];
      `ADDR_ORIENT:     m_set.orientation = data[1:0];
      `ADDR_FLIP_H:     m_set.flip_horizontal = data[0];
      `ADDR_FF_SOUND:   m_set.fastforward_sound = data[0];
      default:          m_set = m_set;
    endcase
    r.kind = ROW_WRITE;
    r.addr = addr;
    r.data = data;
    r.exp_set = m_set;
    rows.push_back(r);
  endfunction

  function automatic void idle_row(int n);
    row_t r;
    r = '0;
    r.kind = ROW_IDLE;
    r.count = 16'(n);
    r.exp_set = m_set;
    rows.push_back(r);
  endfunction

  function automatic void tick_row(logic hb, logic vb, logic hs, logic vs,
                                   logic [23:0] pix, logic isv);
    row_t r;
    logic de;
    logic vert;
    r = '0;
    de = ~(hb | vb);
    case (m_set.orientation)
      `ORIENT_AUTO:     vert = isv;
      `ORIENT_VERTICAL: vert = 1'b1;
      default:          vert = 1'b0;
    endcase
    // what leaves now entered on the previous tick
    r.exp_vid.de = m_s1_de;
    r.exp_vid.vs = m_s1_vs;
    r.exp_vid.hs = (m_hs_left == 1);
    if (m_s1_de) begin
      r.exp_vid.rgb = m_s1_rgb;
    end else if (m_s1_fall) begin
      r.exp_vid.rgb.slot.vertical = vert;
    end
    m_s1_fall = m_prev_de & ~de;
    m_s1_de = de;
    m_s1_rgb = pix;
    m_s1_vs = vs & ~m_prev_vs;
    if (hs && !m_prev_hs) begin
      m_hs_left = `HS_DELAY_TICKS;
    end else if (m_hs_left != 0) begin
      m_hs_left--;
    end
    m_prev_de = de;
    m_prev_hs = hs;
    m_prev_vs = vs;
    r.kind = ROW_TICK;
    r.vin = '{rgb: pix, hblank: hb, vblank: vb, hsync: hs, vsync: vs};
    r.isv = isv;
    r.exp_set = m_set;
    rows.push_back(r);
  endfunction

  // hsync, back porch, active pixels, front porch
  function automatic void line_rows(int n_act, logic isv, logic vb, logic vs);
    tick_row(1'b1, vb, 1'b1, vs, 24'hff00ff, isv);
    repeat (2) tick_row(1'b1, vb, 1'b0, vs, 24'hff00ff, isv);
    for (int i = 0; i < n_act; i++) begin
      tick_row(1'b0, vb, 1'b0, vs, 24'h3c5a96 ^ {3{8'(i * 37 + n_act)}}, isv);
    end
    repeat (4) tick_row(1'b1, vb, 1'b0, vs, 24'hff00ff, isv);
  endfunction

  function automatic void build_table();
    m_set = '0;
    {m_s1_rgb, m_s1_de, m_s1_fall, m_s1_vs} = '0;
    {m_prev_de, m_prev_hs, m_prev_vs} = '0;
    m_hs_left = 0;
    write_row(`ADDR_SYSTEM, 32'h3);
    write_row(`ADDR_TURBO, 32'h1);
    write_row(`ADDR_REWIND, 32'h1);
    write_row(`ADDR_TRIPLE_BUF, 32'h1);
    write_row(`ADDR_FLICKER, 32'h2);
    write_row(`ADDR_ORIENT, 32'h3);
    write_row(`ADDR_FLIP_H, 32'h1);
    write_row(`ADDR_FF_SOUND, 32'h1);
    write_row(32'h104, 32'hffff_ffff);
    write_row(`ADDR_SYSTEM, 32'hffff_fffd);
    write_row(`ADDR_TURBO, 32'h2);
    // second reset write lands partway through the hold
    write_row(`ADDR_RESET, 32'h1);
    idle_row(100);
    write_row(`ADDR_RESET, 32'h1);
    idle_row(270);
    write_row(`ADDR_ORIENT, `ORIENT_AUTO);
    line_rows(4, 1'b1, 1'b0, 1'b0);
    line_rows(3, 1'b0, 1'b0, 1'b0);
    write_row(`ADDR_ORIENT, `ORIENT_VERTICAL);
    line_rows(3, 1'b0, 1'b0, 1'b0);
    write_row(`ADDR_ORIENT, 32'h1);
    line_rows(3, 1'b1, 1'b0, 1'b0);
    write_row(`ADDR_ORIENT, `ORIENT_AUTO);
    line_rows(0, 1'b1, 1'b1, 1'b1);
    line_rows(0, 1'b1, 1'b1, 1'b0);
    // a second hsync edge before the pulse restarts the delay
    tick_row(1'b1, 1'b0, 1'b1, 1'b0, 24'hff00ff, 1'b1);
    repeat (5) tick_row(1'b1, 1'b0, 1'b0, 1'b0, 24'hff00ff, 1'b1);
    line_rows(2, 1'b1, 1'b0, 1'b0);
  endfunction

  ////////////////////////////////////////////////////////////
  // watchdog

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_74a);
      cycle_count++;
      if (cycle_limit != 0 && cycle_count > cycle_limit) begin
        $display("run timed out after %0d cycles", cycle_count);
        abort_run();
      end
    end
  end

  initial begin
    row_t r;
    int   gap;
    void'($urandom(32'h3e0f));
    cycle_limit = 0;
    rst_n = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    pix_ce = 1'b0;
    vid_in = '0;
    is_vertical = 1'b0;
    hold_left = 0;
    build_table();
    cycle_limit = 4 * rows.size() * MAX_GAP + `RESET_HOLD_CYCLES;
    repeat (16) @(posedge clk_74a);
    #2;
    rst_n = 1'b1;
    check_settings('0, core_settings);
    check_bit("core_reset", 1'b0, core_reset);
    check_video('0, vid_out);
    foreach (rows[i]) begin
      r = rows[i];
      case (r.kind)
        ROW_WRITE: begin
          bridge_wr = 1'b1;
          bridge_addr = r.addr;
          bridge_wr_data = r.data;
          next_cycle();
          bridge_wr = 1'b0;
        end
        ROW_IDLE: begin
          repeat (r.count) next_cycle();
        end
        default: begin
          pix_ce = 1'b1;
          vid_in = r.vin;
          is_vertical = r.isv;
          next_cycle();
          pix_ce = 1'b0;
          check_video(r.exp_vid, vid_out);
          gap = $urandom_range(MAX_GAP, 0);
          repeat (gap) next_cycle();
          // outputs hold through the gap
          check_video(r.exp_vid, vid_out);
        end
      endcase
      check_settings(r.exp_set, core_settings);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== verif/pocket_video_assert.sv ====
// video output assertions
// bound onto the top level, watches the scaler facing outputs

`timescale 1ns/1ps

module pocket_video_assert
  import pocket_video_pkg::*;
(
  input logic     clk_74a,
  input logic     rst_n,
  input logic     pix_ce,
  input vid_out_t vid_out
);

  logic de_last;

  // de as it stood before the latest tick
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      de_last <= 1'b0;
    end else if (pix_ce) begin
      de_last <= vid_out.de;
    end
  end

  vs_one_tick: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    (pix_ce && vid_out.vs) |=> !vid_out.vs
  ) else $error("vs high on two consecutive ticks");

  hs_vs_apart: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    !(vid_out.hs && vid_out.vs)
  ) else $error("hs and vs high together");

  // only the slot word may be nonzero in blanking
  blank_is_black: assert property (
    @(posedge clk_74a) disable iff (!rst_n)
    (!vid_out.de && (vid_out.rgb != '0)) |-> de_last
  ) else $error("nonzero rgb in blanking outside the slot pixel");

endmodule

// ==== hw/pocket_video_top.sv ====
// pocket video top
// bridge settings decoder beside the two stage video output
// conditioner, all on clk_74a

`timescale 1ns/1ps

`include "pocket_video_consts.svh"

module pocket_video_top
  import pocket_video_pkg::*;
(
  input  logic                 clk_74a,
  input  logic                 rst_n,
  input  logic                 bridge_wr,
  input  logic [`BRIDGE_W-1:0] bridge_addr,
  input  logic [`BRIDGE_W-1:0] bridge_wr_data,
  input  logic                 pix_ce,
  input  vid_in_t              vid_in,
  input  logic                 is_vertical,
  output core_settings_t       core_settings,
  output logic                 core_reset,
  output vid_out_t             vid_out
);

  vid_stage_t stage;

  bridge_settings bridge_settings_i (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .core_settings  (core_settings),
    .core_reset     (core_reset)
  );

  video_timing_stage video_timing_stage_i (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .pix_ce  (pix_ce),
    .vid_in  (vid_in),
    .stage   (stage)
  );

  // orientation setting goes straight to the slot word logic
  video_pixel_stage video_pixel_stage_i (
    .clk_74a     (clk_74a),
    .rst_n       (rst_n),
    .pix_ce      (pix_ce),
    .stage       (stage),
    .orientation (core_settings.orientation),
    .is_vertical (is_vertical),
    .vid_out     (vid_out)
  );

endmodule

// ==== hw/video_pixel_stage.sv ====
// video pixel stage
// output register of the video pipeline: picks colour, slot word or
// black for each tick and registers it with de, hs and vs

`timescale 1ns/1ps

`include "pocket_video_consts.svh"

module video_pixel_stage
  import pocket_video_pkg::*;
(
  input  logic                 clk_74a,
  input  logic                 rst_n,
  input  logic                 pix_ce,
  input  vid_stage_t           stage,
  input  logic [`ORIENT_W-1:0] orientation,
  input  logic                 is_vertical,
  output vid_out_t             vid_out
);

  logic      orient_vertical;
  rgb_word_u rgb_next;

  // auto follows the core, vertical code forces it, anything else is flat
  assign orient_vertical = (orientation == `ORIENT_AUTO) ? is_vertical :
                           (orientation == `ORIENT_VERTICAL);

  ////////////////////////////////////////////////////////////
  // output word select

  always_comb begin
    rgb_next = '0;
    if (stage.de) begin
      rgb_next.colour.r = stage.rgb[23:16];
      rgb_next.colour.g = stage.rgb[15:8];
      rgb_next.colour.b = stage.rgb[7:0];
    end else if (stage.de_fall) begin
      // first blank pixel tells the scaler which slot to use
      rgb_next.slot.vertical = orient_vertical;
    end
  end

  ////////////////////////////////////////////////////////////
  // output register, holds between ticks

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      vid_out <= '0;
    end else if (pix_ce) begin
      vid_out.rgb <= rgb_next;
      vid_out.de  <= stage.de;
      vid_out.hs  <= stage.hs_pulse;
      vid_out.vs  <= stage.vs_pulse;
    end
  end

endmodule

// ==== hw/video_timing_stage.sv ====
// video timing stage
// first register of the video pipeline that builds data enable, finds
// sync edges, delays hsync clear of vsync and marks the end of active video

`timescale 1ns/1ps

`include "pocket_video_consts.svh"

module video_timing_stage
  import pocket_video_pkg::*;
(
  input  logic       clk_74a,
  input  logic       rst_n,
  input  logic       pix_ce,
  input  vid_in_t    vid_in,
  output vid_stage_t stage
);

  localparam int HS_CNT_W = $clog2(`HS_DELAY_TICKS + 1);
  localparam logic [HS_CNT_W-1:0] HS_LOAD = HS_CNT_W'(`HS_DELAY_TICKS);
  // pulse one tick early since the pixel stage adds the last one
  localparam logic [HS_CNT_W-1:0] HS_FIRE = HS_CNT_W'(2);

  logic                de;
  logic                hs_rise;
  logic                vs_rise;
  logic                hs_prev;
  logic                vs_prev;
  logic [HS_CNT_W-1:0] hs_cnt;
  logic [`RGB_W-1:0]   rgb_q;
  logic                de_q;
  logic                de_fall_q;
  logic                hs_pulse_q;
  logic                vs_pulse_q;

  assign de      = ~(vid_in.hblank | vid_in.vblank);
  assign hs_rise = vid_in.hsync & ~hs_prev;
  assign vs_rise = vid_in.vsync & ~vs_prev;

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      hs_prev    <= 1'b0;
      vs_prev    <= 1'b0;
      hs_cnt     <= '0;
      de_q       <= 1'b0;
      de_fall_q  <= 1'b0;
      hs_pulse_q <= 1'b0;
      vs_pulse_q <= 1'b0;
    end else if (pix_ce) begin
      hs_prev    <= vid_in.hsync;
      vs_prev    <= vid_in.vsync;
      de_q       <= de;
      // de_q still holds the de of the previous tick here
      de_fall_q  <= de_q & ~de;
      vs_pulse_q <= vs_rise;
      // a fresh hsync edge cancels a pending pulse
      hs_pulse_q <= ~hs_rise && (hs_cnt == HS_FIRE);
      if (hs_rise) begin
        hs_cnt <= HS_LOAD;
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk_74a) begin
    if (pix_ce) begin
      rgb_q <= vid_in.rgb;
    end
  end

  assign stage = '{rgb: rgb_q, de: de_q, de_fall: de_fall_q,
                   hs_pulse: hs_pulse_q, vs_pulse: vs_pulse_q};

endmodule

// ==== hw/bridge_settings.sv ====
// bridge settings decoder
// turns single cycle bridge writes into core configuration bits and
// holds the core in reset for a fixed count after a reset write

`timescale 1ns/1ps

`include "pocket_video_consts.svh"

module bridge_settings
  import pocket_video_pkg::*;
(
  input  logic                 clk_74a,
  input  logic                 rst_n,
  input  logic                 bridge_wr,
  input  logic [`BRIDGE_W-1:0] bridge_addr,
  input  logic [`BRIDGE_W-1:0] bridge_wr_data,
  output core_settings_t       core_settings,
  output logic                 core_reset
);

  localparam int HOLD_W = $clog2(`RESET_HOLD_CYCLES + 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(`RESET_HOLD_CYCLES);

  logic [HOLD_W-1:0] hold_cnt;
  logic              reset_wr;

  assign reset_wr = bridge_wr && (bridge_addr == `ADDR_RESET);

  ////////////////////////////////////////////////////////////
  // settings register

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      core_settings <= '0;
    end else if (bridge_wr) begin
      // each address owns one field, data comes from the low bits
      case (bridge_addr)
        `ADDR_SYSTEM:     core_settings.system <= bridge_wr_data[1:0];
        `ADDR_TURBO:      core_settings.cpu_turbo <= bridge_wr_data[0];
        `ADDR_REWIND:     core_settings.rewind_capture <= bridge_wr_data[0];
        `ADDR_TRIPLE_BUF: core_settings.triple_buffer <= bridge_wr_data[0];
        `ADDR_FLICKER:    core_settings.flickerblend <= bridge_wr_data[1:0];
        `ADDR_ORIENT: begin
          core_settings.orientation <= bridge_wr_data[`ORIENT_W-1:0];
        end
        `ADDR_FLIP_H:     core_settings.flip_horizontal <= bridge_wr_data[0];
        `ADDR_FF_SOUND:   core_settings.fastforward_sound <= bridge_wr_data[0];
        default: begin
          // unmapped, ignored
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // core reset hold

  // a new reset write restarts the count
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= '0;
    end else if (reset_wr) begin
      hold_cnt <= HOLD_LOAD;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // counts HOLD_LOAD down to 1, so exactly that many cycles
  assign core_reset = (hold_cnt != '0);

endmodule

// ==== hw/pocket_video_pkg.sv ====
// pocket video types
// settings word, core video bundles and the scaler output word

`include "pocket_video_consts.svh"

package pocket_video_pkg;

  // configuration bits written over the bridge
  typedef struct packed {
    logic [1:0]           system;
    logic                 cpu_turbo;
    logic                 rewind_capture;
    logic                 triple_buffer;
    logic [1:0]           flickerblend;
    logic [`ORIENT_W-1:0] orientation;
    logic                 flip_horizontal;
    logic                 fastforward_sound;
  } core_settings_t;

  // raw video from the emulation core
  typedef struct packed {
    logic [`RGB_W-1:0] rgb;
    logic              hblank;
    logic              vblank;
    logic              hsync;
    logic              vsync;
  } vid_in_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_colour_t;

  // scaler slot word, sent in the first blank pixel of a line
  typedef struct packed {
    logic [9:0]  pad_hi;
    logic        vertical;
    logic [12:0] pad_lo;
  } rgb_slot_t;

  typedef union packed {
    rgb_colour_t colour;
    rgb_slot_t   slot;
  } rgb_word_u;

  typedef struct packed {
    rgb_word_u rgb;
    logic      de;
    logic      hs;
    logic      vs;
  } vid_out_t;

  // timing stage to pixel stage
  typedef struct packed {
    logic [`RGB_W-1:0] rgb;
    logic              de;
    logic              de_fall;
    logic              hs_pulse;
    logic              vs_pulse;
  } vid_stage_t;

endpackage

// ==== hw/pocket_video_consts.svh ====
// pocket video constants
// bridge address map, field widths and timing lengths shared by
// the settings decoder and the video conditioner

`ifndef POCKET_VIDEO_CONSTS_SVH
`define POCKET_VIDEO_CONSTS_SVH

// bridge bus
`define BRIDGE_W 32

// settings addresses, byte offsets on the bridge
`define ADDR_RESET      32'h050
`define ADDR_SYSTEM     32'h100
`define ADDR_TURBO      32'h110
`define ADDR_REWIND     32'h114
`define ADDR_TRIPLE_BUF 32'h200
`define ADDR_FLICKER    32'h204
`define ADDR_ORIENT     32'h208
`define ADDR_FLIP_H     32'h20C
`define ADDR_FF_SOUND   32'h300

// core reset hold, in clk_74a cycles
`define RESET_HOLD_CYCLES 256

// video
`define HS_DELAY_TICKS  7
`define ORIENT_W        2
`define ORIENT_AUTO     2'd0
`define ORIENT_VERTICAL 2'd2
`define RGB_W           24

`endif
